// File: common/dma_pkg.sv
package dma_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////
    localparam int WORD_W      = 32;
    localparam int BE_W        = WORD_W / 8;
    localparam int MEM_AW      = 16;   // word address inside one memory
    localparam int BYTE_AW     = 32;
    localparam int SIZE_W      = 16;
    localparam int REG_AW      = 8;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [BE_W-1:0]     byte_en_t;
    typedef logic [MEM_AW-1:0]   mem_addr_t;
    typedef logic [BYTE_AW-1:0]  byte_addr_t;
    typedef logic [1:0]          byte_off_t;
    typedef logic [SIZE_W-1:0]   xfer_size_t;
    typedef logic [REG_AW-1:0]   reg_addr_t;

    // one memory port request, read when we is zero
    typedef struct packed {
        logic       en;
        byte_en_t   we;
        mem_addr_t  addr;
        word_t      wdata;
    } mem_req_t;

    typedef struct packed {
        byte_addr_t src;
        byte_addr_t dst;
        xfer_size_t size;
    } dma_cfg_t;

    //////////////////////////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////////////////////////
    localparam reg_addr_t REG_SRC  = 8'h00;
    localparam reg_addr_t REG_DST  = 8'h04;
    localparam reg_addr_t REG_SIZE = 8'h08;
    localparam reg_addr_t REG_MODE = 8'h0C;
    localparam reg_addr_t REG_INT  = 8'h10;

    localparam int MEM_SEL_BIT = 20;        // 1 -> mem0, 0 -> mem1
    localparam int DEFAULT_FIFO_DEPTH = 16;

endpackage

// File: engine/byte_aligner.sv
`timescale 1ns/10ps

module byte_aligner (
    input  logic                CLK,
    input  logic                RSTN,
    input  logic                load,
    input  dma_pkg::byte_off_t  pad,
    input  logic                in_valid,
    input  dma_pkg::word_t      in_word,
    input  dma_pkg::byte_off_t  in_skip,
    input  logic [2:0]          in_count,   // 1 to 4
    input  logic                flush,
    output logic                out_valid,
    output dma_pkg::word_t      out_word
);

    logic [23:0]     hold_q;     // at most 3 bytes left over
    logic [2:0]      cnt;
    logic            flush_q;
    logic [55:0]     acc;        // held bytes plus one incoming word
    logic [2:0]      total;
    dma_pkg::word_t  shifted;
    logic            full_word;

    //////////////////////////////////////////////////////////////////////
    // append source bytes behind the held ones
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        acc     = {32'b0, hold_q};
        shifted = in_word >> {in_skip, 3'b000};   // drop leading bytes
        total   = cnt;
        if (in_valid) begin
            for (int i = 0; i < 4; i++) begin
                if (3'(i) < in_count) acc[(int'(cnt) + i) * 8 +: 8] = shifted[i * 8 +: 8];
            end
            total = cnt + in_count;
        end
    end

    assign full_word = in_valid && total >= 3'd4;
    assign out_valid = full_word || (flush_q && cnt != 3'd0);
    assign out_word  = acc[31:0];   // partial word on flush, upper bytes zero

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            cnt     <= 3'd0;
            flush_q <= 1'b0;
        end else begin
            flush_q <= flush;
            if (load)
                cnt <= {1'b0, pad};     // placeholders, masked on write
            else if (full_word)
                cnt <= total - 3'd4;
            else if (in_valid)
                cnt <= total;
            else if (flush_q)
                cnt <= 3'd0;
        end
    end

    always_ff @(posedge CLK) begin
        if (load)
            hold_q <= '0;
        else if (full_word)
            hold_q <= acc[55:32];
        else if (in_valid)
            hold_q <= acc[23:0];
    end

endmodule

// File: engine/word_fifo.sv
`timescale 1ns/10ps

module word_fifo #(
    parameter int FIFO_DEPTH = dma_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic            CLK,
    input  logic            RSTN,
    input  logic            push,
    input  dma_pkg::word_t  push_data,
    input  logic            pop,
    output dma_pkg::word_t  pop_data,
    output logic            full,
    output logic            empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    dma_pkg::word_t  mem [FIFO_DEPTH];
    logic [AW:0]     wr_ptr;     // extra bit tells full from empty
    logic [AW:0]     rd_ptr;

    assign empty    = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign pop_data = mem[rd_ptr[AW-1:0]];  // show-ahead head

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (push) mem[wr_ptr[AW-1:0]] <= push_data;
    end

    a_no_overflow: assert property (@(posedge CLK) disable iff (!RSTN)
        !(push && full));

    a_no_underflow: assert property (@(posedge CLK) disable iff (!RSTN)
        !(pop && empty));

endmodule

// File: engine/dma_ctrl.sv
`timescale 1ns/10ps

module dma_ctrl #(
    parameter int FIFO_DEPTH = dma_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic               CLK,
    input  logic               RSTN,
    input  logic               start,
    input  dma_pkg::dma_cfg_t  cfg,
    output logic               done,
    output dma_pkg::mem_req_t  mem0_req,
    output dma_pkg::mem_req_t  mem1_req,
    input  dma_pkg::word_t     mem0_rdata,
    input  dma_pkg::word_t     mem1_rdata
);

    typedef enum logic [2:0] {IDLE, READ, FLUSH, WRITE, DONE} dma_state_t;

    dma_state_t           state;
    dma_pkg::dma_cfg_t    cfg_q;
    dma_pkg::mem_addr_t   rd_addr;
    dma_pkg::mem_addr_t   wr_addr;
    dma_pkg::xfer_size_t  rem;        // source bytes not yet read
    logic [16:0]          wr_left;    // destination words to write
    logic [16:0]          dst_words;
    logic                 first;      // first word of the current phase
    logic                 rd_vld;
    dma_pkg::byte_off_t   rd_skip;
    logic [2:0]           rd_cnt;
    dma_pkg::byte_off_t   skip;
    logic [2:0]           avail;
    logic [2:0]           cnt;
    logic                 last_rd;
    logic                 src_mem0;
    logic                 dst_mem0;
    logic                 to_mem0;
    dma_pkg::mem_req_t    req;
    dma_pkg::byte_en_t    wr_mask;
    dma_pkg::byte_off_t   end_off;
    dma_pkg::word_t       al_word;
    dma_pkg::word_t       fifo_head;
    logic                 al_valid;
    logic                 fifo_empty;
    logic                 pop;

    assign dst_words = ({1'b0, cfg.size} + 17'(cfg.dst[1:0]) + 17'd3) >> 2;
    assign src_mem0  = cfg_q.src[dma_pkg::MEM_SEL_BIT];
    assign dst_mem0  = cfg_q.dst[dma_pkg::MEM_SEL_BIT];

    // bytes taken from the word being read
    assign skip    = first ? cfg_q.src[1:0] : 2'd0;
    assign avail   = 3'd4 - {1'b0, skip};
    assign cnt     = (rem < 16'(avail)) ? rem[2:0] : avail;
    assign last_rd = rem <= 16'(avail);

    assign pop     = (state == WRITE) && !fifo_empty;
    assign done    = (state == DONE);
    assign end_off = cfg_q.dst[1:0] + cfg_q.size[1:0] - 2'd1;

    always_comb begin
        wr_mask = 4'b1111;
        if (first) wr_mask = wr_mask & (4'b1111 << cfg_q.dst[1:0]);
        if (wr_left == 17'd1) wr_mask = wr_mask & (4'b1111 >> (2'd3 - end_off));
    end

    always_comb begin
        req     = '0;
        to_mem0 = src_mem0;
        if (state == READ) begin
            req.en   = 1'b1;
            req.addr = rd_addr;
        end else if (pop) begin
            req.en    = 1'b1;
            req.we    = wr_mask;
            req.addr  = wr_addr;
            req.wdata = fifo_head;
            to_mem0   = dst_mem0;
        end
    end

    assign mem0_req = to_mem0 ? req : '0;
    assign mem1_req = to_mem0 ? '0 : req;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            state   <= IDLE;
            first   <= 1'b0;
            rd_vld  <= 1'b0;
            rem     <= '0;
            wr_left <= '0;
        end else begin
            rd_vld <= (state == READ);
            case (state)
                IDLE: if (start) begin
                    first   <= 1'b1;
                    rem     <= cfg.size;
                    wr_left <= dst_words;
                    state   <= (cfg.size == '0) ? DONE : READ;
                end
                READ: begin
                    first <= 1'b0;
                    rem   <= rem - 16'(cnt);
                    if (last_rd) state <= FLUSH;
                end
                FLUSH: begin
                    first <= 1'b1;  // rearmed for the write phase
                    state <= WRITE;
                end
                WRITE: if (pop) begin
                    first   <= 1'b0;
                    wr_left <= wr_left - 17'd1;
                    if (wr_left == 17'd1) state <= DONE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == IDLE && start) begin
            cfg_q   <= cfg;
            rd_addr <= cfg.src[2 +: $bits(dma_pkg::mem_addr_t)];
            wr_addr <= cfg.dst[2 +: $bits(dma_pkg::mem_addr_t)];
        end
        if (state == READ) begin
            rd_addr <= rd_addr + 1'b1;
            rd_skip <= skip;
            rd_cnt  <= cnt;
        end
        if (pop) wr_addr <= wr_addr + 1'b1;
    end

    byte_aligner u_byte_aligner (
        .CLK       (CLK),
        .RSTN      (RSTN),
        .load      (state == IDLE && start),
        .pad       (cfg.dst[1:0]),
        .in_valid  (rd_vld),
        .in_word   (src_mem0 ? mem0_rdata : mem1_rdata),
        .in_skip   (rd_skip),
        .in_count  (rd_cnt),
        .flush     (state == FLUSH),
        .out_valid (al_valid),
        .out_word  (al_word)
    );

    word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_word_fifo (
        .CLK       (CLK),
        .RSTN      (RSTN),
        .push      (al_valid),
        .push_data (al_word),
        .pop       (pop),
        .pop_data  (fifo_head),
        .full      (),
        .empty     (fifo_empty)
    );

    // read phase has no back-pressure so the whole destination must fit
    a_fifo_limit: assert property (@(posedge CLK) disable iff (!RSTN)
        (state == IDLE && start) |-> (cfg.size == '0 || dst_words <= FIFO_DEPTH));

    // every write lands in exactly one memory with some byte enabled
    a_one_writer: assert property (@(posedge CLK) disable iff (!RSTN)
        pop |-> ((|mem0_req.we) != (|mem1_req.we)));

endmodule

// File: source/apb_regs.sv
`timescale 1ns/10ps

module apb_regs (
    input  logic                CLK,
    input  logic                RSTN,
    input  logic                PSEL,
    input  logic                PENABLE,
    input  logic                PWRITE,
    input  dma_pkg::reg_addr_t  PADDR,
    input  dma_pkg::word_t      PWDATA,
    output dma_pkg::word_t      PRDATA,
    output logic                PREADY,
    input  logic                done,
    output logic                start,
    output dma_pkg::dma_cfg_t   cfg,
    output logic                INTR
);

    dma_pkg::byte_addr_t  src_q;
    dma_pkg::byte_addr_t  dst_q;
    dma_pkg::xfer_size_t  size_q;
    logic                 mode_q;   // also the busy flag
    logic                 int_q;
    logic                 access;
    dma_pkg::word_t       rdata;

    // master holds psel/penable through the ready cycle
    assign access = PSEL && PENABLE && !PREADY;

    always_comb begin
        case (PADDR)
            dma_pkg::REG_SRC:  rdata = src_q;
            dma_pkg::REG_DST:  rdata = dst_q;
            dma_pkg::REG_SIZE: rdata = {16'b0, size_q};
            dma_pkg::REG_MODE: rdata = {31'b0, mode_q};
            dma_pkg::REG_INT:  rdata = {31'b0, int_q};
            default:           rdata = '0;
        endcase
    end

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            src_q  <= '0;
            dst_q  <= '0;
            size_q <= '0;
            mode_q <= 1'b0;
            int_q  <= 1'b0;
            start  <= 1'b0;
            PREADY <= 1'b0;
            PRDATA <= '0;
        end else begin
            PREADY <= access;
            start  <= 1'b0;
            if (access && PWRITE) begin
                case (PADDR)
                    dma_pkg::REG_SRC:  src_q  <= PWDATA;
                    dma_pkg::REG_DST:  dst_q  <= PWDATA;
                    dma_pkg::REG_SIZE: size_q <= PWDATA[15:0];
                    dma_pkg::REG_MODE: begin
                        if (!mode_q) begin      // ignored while a copy runs
                            mode_q <= PWDATA[0];
                            start  <= PWDATA[0];
                        end
                    end
                    dma_pkg::REG_INT:  if (PWDATA[0]) int_q <= 1'b0;
                    default: ;
                endcase
            end
            if (access && !PWRITE) PRDATA <= rdata;
            if (done) begin
                mode_q <= 1'b0;
                int_q  <= 1'b1;     // wins over a same-cycle clear
            end
        end
    end

    assign cfg.src  = src_q;
    assign cfg.dst  = dst_q;
    assign cfg.size = size_q;
    assign INTR     = done;

    // completion only arrives while a copy runs
    a_done_busy: assert property (@(posedge CLK) disable iff (!RSTN)
        done |-> mode_q);

endmodule

// File: source/dma_top.sv
`timescale 1ns/10ps

module dma_top #(
    parameter int FIFO_DEPTH = dma_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                CLK,
    input  logic                RSTN,
    output logic                INTR,

    // apb slave
    input  logic                PSEL,
    input  logic                PENABLE,
    input  logic                PWRITE,
    input  dma_pkg::reg_addr_t  PADDR,
    input  dma_pkg::word_t      PWDATA,
    output dma_pkg::word_t      PRDATA,
    output logic                PREADY,

    // memory ports
    output dma_pkg::mem_req_t   mem0_req,
    output dma_pkg::mem_req_t   mem1_req,
    input  dma_pkg::word_t      mem0_rdata,
    input  dma_pkg::word_t      mem1_rdata
);

    logic               start;
    logic               done;
    dma_pkg::dma_cfg_t  cfg;

    apb_regs u_apb_regs (
        .CLK      (CLK),
        .RSTN     (RSTN),
        .PSEL     (PSEL),
        .PENABLE  (PENABLE),
        .PWRITE   (PWRITE),
        .PADDR    (PADDR),
        .PWDATA   (PWDATA),
        .PRDATA   (PRDATA),
        .PREADY   (PREADY),
        .done     (done),
        .start    (start),
        .cfg      (cfg),
        .INTR     (INTR)
    );

    dma_ctrl #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dma_ctrl (
        .CLK        (CLK),
        .RSTN       (RSTN),
        .start      (start),
        .cfg        (cfg),
        .done       (done),
        .mem0_req   (mem0_req),
        .mem1_req   (mem1_req),
        .mem0_rdata (mem0_rdata),
        .mem1_rdata (mem1_rdata)
    );

endmodule

// File: verification/tb_dma.sv
`timescale 1ns/10ps

module tb_dma;

    localparam int FIFO_DEPTH   = dma_pkg::DEFAULT_FIFO_DEPTH;
    localparam int MEM_WORDS    = 65536;
    localparam int N_XFERS      = 21;
    localparam int N_APB        = N_XFERS * 8 + 16;
    localparam int XFER_CYCLES  = 2 * FIFO_DEPTH + 40;
    localparam int LIMIT_CYCLES = N_XFERS * XFER_CYCLES + N_APB * 200;

    logic                CLK;
    logic                RSTN;
    logic                INTR;
    logic                PSEL;
    logic                PENABLE;
    logic                PWRITE;
    dma_pkg::reg_addr_t  PADDR;
    dma_pkg::word_t      PWDATA;
    dma_pkg::word_t      PRDATA;
    logic                PREADY;
    dma_pkg::mem_req_t   mem0_req;
    dma_pkg::mem_req_t   mem1_req;
    dma_pkg::mem_req_t   req0_q;
    dma_pkg::mem_req_t   req1_q;
    dma_pkg::word_t      mem0_rdata;
    dma_pkg::word_t      mem1_rdata;

    dma_pkg::word_t  mem0 [MEM_WORDS];
    dma_pkg::word_t  mem1 [MEM_WORDS];
    dma_pkg::word_t  exp0 [MEM_WORDS];   // reference image
    dma_pkg::word_t  exp1 [MEM_WORDS];
    dma_pkg::word_t  snap0 [MEM_WORDS];  // taken before each start
    dma_pkg::word_t  snap1 [MEM_WORDS];

    logic [31:0]  lfsr_state = 32'h81bc_1174;
    int           errors = 0;
    int           tests = 0;
    int           failed_tests = 0;
    int           intr_count = 0;
    int           req_count = 0;

    dma_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dma_top (
        .CLK        (CLK),
        .RSTN       (RSTN),
        .INTR       (INTR),
        .PSEL       (PSEL),
        .PENABLE    (PENABLE),
        .PWRITE     (PWRITE),
        .PADDR      (PADDR),
        .PWDATA     (PWDATA),
        .PRDATA     (PRDATA),
        .PREADY     (PREADY),
        .mem0_req   (mem0_req),
        .mem1_req   (mem1_req),
        .mem0_rdata (mem0_rdata),
        .mem1_rdata (mem1_rdata)
    );

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;

    //////////////////////////////////////////////////////////////////////
    // memory models with one-cycle read latency
    //////////////////////////////////////////////////////////////////////
    function automatic dma_pkg::word_t merge_bytes(input dma_pkg::word_t old,
        input dma_pkg::word_t wdata, input dma_pkg::byte_en_t we);
        dma_pkg::word_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (we[b]) r[8*b +: 8] = wdata[8*b +: 8];
        end
        return r;
    endfunction

    always @(posedge CLK) begin
        req0_q <= mem0_req;
        req1_q <= mem1_req;
    end

    always @(negedge CLK) begin
        if (req0_q.en) begin
            if (req0_q.we == '0) mem0_rdata = mem0[req0_q.addr];
            else mem0[req0_q.addr] = merge_bytes(mem0[req0_q.addr], req0_q.wdata, req0_q.we);
        end
        if (req1_q.en) begin
            if (req1_q.we == '0) mem1_rdata = mem1[req1_q.addr];
            else mem1[req1_q.addr] = merge_bytes(mem1[req1_q.addr], req1_q.wdata, req1_q.we);
        end
    end

    always @(negedge CLK) begin
        if (INTR) intr_count++;
        if (mem0_req.en || mem1_req.en) req_count++;
    end

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic dma_pkg::word_t fill_word(input logic sel, input logic [15:0] idx);
        return {idx[7:0] ^ 8'h3c, idx[15:8] ^ (sel ? 8'hb1 : 8'h4e),
                idx[7:0] + idx[15:8] + 8'h17, ~idx[7:0]};
    endfunction

    function automatic dma_pkg::byte_addr_t make_addr(input logic sel,
        input dma_pkg::mem_addr_t word, input dma_pkg::byte_off_t off);
        dma_pkg::byte_addr_t a;
        a = '0;
        a[dma_pkg::MEM_SEL_BIT] = sel;   // 1 -> mem0
        a[17:2] = word;
        a[1:0] = off;
        return a;
    endfunction

    function automatic logic [7:0] snap_byte(input dma_pkg::byte_addr_t a);
        dma_pkg::word_t w;
        w = a[dma_pkg::MEM_SEL_BIT] ? snap0[a[17:2]] : snap1[a[17:2]];
        return w[8*a[1:0] +: 8];
    endfunction

    task automatic set_exp_byte(input dma_pkg::byte_addr_t a, input logic [7:0] b);
        if (a[dma_pkg::MEM_SEL_BIT]) exp0[a[17:2]][8*a[1:0] +: 8] = b;
        else exp1[a[17:2]][8*a[1:0] +: 8] = b;
    endtask

    task automatic check_word(input string name, input dma_pkg::word_t got,
        input dma_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // apb master
    //////////////////////////////////////////////////////////////////////
    task automatic apb_access(input logic write, input dma_pkg::reg_addr_t addr,
        input dma_pkg::word_t wdata, output dma_pkg::word_t rdata);
        int waited;
        waited = 0;
        @(negedge CLK);
        PSEL = 1'b1;
        PWRITE = write;
        PADDR = addr;
        PWDATA = wdata;
        PENABLE = 1'b0;
        @(negedge CLK);
        PENABLE = 1'b1;
        do begin
            @(negedge CLK);
            waited++;
        end while (!PREADY && waited < 200);
        rdata = PRDATA;
        PSEL = 1'b0;
        PENABLE = 1'b0;
        PWRITE = 1'b0;
        if (!PREADY) begin
            errors++;
            $display("APB access to offset 0x%02h never got PREADY", addr);
        end else if (waited != 1) begin
            errors++;
            $display("APB access to offset 0x%02h took %0d cycles, not 1", addr, waited);
        end
    endtask

    task automatic apb_write(input dma_pkg::reg_addr_t addr, input dma_pkg::word_t data);
        dma_pkg::word_t unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input dma_pkg::reg_addr_t addr, output dma_pkg::word_t data);
        apb_access(1'b0, addr, '0, data);
    endtask

    task automatic compare_mems();
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (mem0[i] !== exp0[i]) begin
                check_word($sformatf("mem0[0x%04h]", i), mem0[i], exp0[i]);
                break;
            end
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (mem1[i] !== exp1[i]) begin
                check_word($sformatf("mem1[0x%04h]", i), mem1[i], exp1[i]);
                break;
            end
        end
    endtask

    // one transfer and its completion checks
    task automatic run_copy(input dma_pkg::byte_addr_t src, input dma_pkg::byte_addr_t dst,
        input dma_pkg::xfer_size_t size);
        dma_pkg::word_t rd;
        int             intr_before;
        int             req_before;
        int             n;
        logic           seen;
        snap0 = exp0;
        snap1 = exp1;
        for (int k = 0; k < int'(size); k++) begin
            set_exp_byte(dma_pkg::byte_addr_t'(dst + k),
                         snap_byte(dma_pkg::byte_addr_t'(src + k)));
        end
        apb_write(dma_pkg::REG_SRC, src);
        apb_write(dma_pkg::REG_DST, dst);
        apb_write(dma_pkg::REG_SIZE, dma_pkg::word_t'(size));
        intr_before = intr_count;
        req_before = req_count;
        apb_write(dma_pkg::REG_MODE, 32'h1);
        seen = 1'b0;
        for (n = 0; n < XFER_CYCLES && !seen; n++) begin
            @(negedge CLK);
            seen = INTR;
        end
        if (!seen) begin
            errors++;
            $display("no INTR within %0d cycles of the start", XFER_CYCLES);
        end
        repeat (2) @(negedge CLK);
        apb_read(dma_pkg::REG_MODE, rd);
        check_word("MODE", rd, 32'h0);
        apb_read(dma_pkg::REG_INT, rd);
        check_bit("INT", rd[0], 1'b1);
        apb_write(dma_pkg::REG_INT, 32'h1);
        apb_read(dma_pkg::REG_INT, rd);
        check_bit("INT after clear", rd[0], 1'b0);
        check_word("INTR pulses", dma_pkg::word_t'(intr_count - intr_before), 32'd1);
        if (size == '0) begin
            check_word("memory requests", dma_pkg::word_t'(req_count - req_before), 32'd0);
        end
        compare_mems();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic register_access();
        int             e;
        dma_pkg::word_t rd;
        e = errors;
        apb_write(dma_pkg::REG_SRC, 32'h0012_3457);
        apb_write(dma_pkg::REG_DST, 32'h0010_0abc);
        apb_write(dma_pkg::REG_SIZE, 32'h0000_0033);
        apb_read(dma_pkg::REG_SRC, rd);
        check_word("SRC", rd, 32'h0012_3457);
        apb_read(dma_pkg::REG_DST, rd);
        check_word("DST", rd, 32'h0010_0abc);
        apb_read(dma_pkg::REG_SIZE, rd);
        check_word("SIZE", rd, 32'h0000_0033);
        apb_read(8'h14, rd);
        check_word("unmapped 0x14", rd, 32'h0);
        finish_test("registers", e);
    endtask

    task automatic aligned_copy();
        int e;
        e = errors;
        run_copy(make_addr(1'b0, 16'h0100, 2'd0), make_addr(1'b1, 16'h0200, 2'd0), 16'd32);
        finish_test("aligned", e);
    endtask

    task automatic misaligned_copies();
        int                  e;
        int                  span;
        logic                to_mem1;
        dma_pkg::xfer_size_t size;
        dma_pkg::mem_addr_t  sw;
        dma_pkg::mem_addr_t  dw;
        e = errors;
        for (int so = 0; so < 4; so++) begin
            for (int doff = 0; doff < 4; doff++) begin
                span = 64 - doff;   // keeps destination within 16 words
                size = dma_pkg::xfer_size_t'(1 + (random_bits(6) % span));
                sw = dma_pkg::mem_addr_t'(16'h0400 + random_bits(10));
                dw = dma_pkg::mem_addr_t'(16'h2000 + random_bits(10));
                to_mem1 = ((so * 4 + doff) % 2) == 0;
                run_copy(make_addr(to_mem1, sw, 2'(so)),
                         make_addr(!to_mem1, dw, 2'(doff)), size);
            end
        end
        finish_test("misaligned", e);
    endtask

    task automatic overlapping_copies();
        int e;
        e = errors;
        run_copy(make_addr(1'b1, 16'h3000, 2'd0), make_addr(1'b1, 16'h3001, 2'd1), 16'd40);
        run_copy(make_addr(1'b1, 16'h3102, 2'd1), make_addr(1'b1, 16'h3100, 2'd2), 16'd45);
        finish_test("overlap", e);
    endtask

    task automatic completion_status();
        int e;
        e = errors;
        run_copy(make_addr(1'b1, 16'h4000, 2'd2), make_addr(1'b0, 16'h4100, 2'd3), 16'd13);
        run_copy(make_addr(1'b1, 16'h4200, 2'd1), make_addr(1'b0, 16'h4300, 2'd0), 16'd0);
        finish_test("completion", e);
    endtask

    initial begin
        RSTN = 1'b0;
        PSEL = 1'b0;
        PENABLE = 1'b0;
        PWRITE = 1'b0;
        PADDR = '0;
        PWDATA = '0;
        mem0_rdata = '0;
        mem1_rdata = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem0[i] = fill_word(1'b1, 16'(i));
            mem1[i] = fill_word(1'b0, 16'(i));
        end
        exp0 = mem0;
        exp1 = mem1;
        repeat (16) @(negedge CLK);
        RSTN = 1'b1;
        register_access();
        aligned_copy();
        misaligned_copies();
        overlapping_copies();
        completion_status();
        $display("%0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // watchdog
    initial begin
        repeat (LIMIT_CYCLES) @(posedge CLK);
        $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: filelist.f
common/dma_pkg.sv
engine/byte_aligner.sv
engine/word_fifo.sv
engine/dma_ctrl.sv
source/apb_regs.sv
source/dma_top.sv
verification/tb_dma.sv

// File: run_sim.sh
#!/bin/sh
# Build and run tb_dma with Verilator, pass or fail is read from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dma -f filelist.f -Mdir "$OBJ" -o vtb_dma
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/vtb_dma" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0
